/* sim.f */
+incdir+include
source/armExecPkg.sv
source/operand2Decode.sv
source/barrelShifter.sv
source/armAlu.sv
source/condFlags.sv
source/executeStage.sv
testbench/executeStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module executeStageTb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VexecuteStageTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "** PASS **"; then
  exit 0
fi
exit 1

/* include/execModel.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Bit-serial shifter model returning {carry, value}
function automatic logic [32:0] modelShift(input logic [31:0] instr, input logic [31:0] rm,
                                           input logic [31:0] rs, input logic cIn);
  logic [31:0] val;
  logic [7:0]  amt;
  logic [1:0]  kind;
  logic        c;
  logic        regLike;
  val     = rm;
  c       = cIn;
  kind    = instr[6:5];
  regLike = instr[4];  // Amount 0 means no shift
  amt     = instr[4] ? rs[7:0] : {3'b000, instr[11:7]};
  if (instr[25]) begin  // Rotated immediate acts like a register ROR
    val     = {24'd0, instr[7:0]};
    amt     = {3'b000, instr[11:8], 1'b0};
    kind    = 2'b11;
    regLike = 1'b1;
  end
  if (kind == 2'b11 && amt == 8'd0 && !regLike) begin
    c   = val[0];  // RRX
    val = {cIn, val[31:1]};
  end else if (kind == 2'b11 && amt != 8'd0) begin
    for (int i = 0; i < int'(amt[4:0]); i++) begin
      val = {val[0], val[31:1]};
    end
    c = val[31];
  end else begin
    for (int i = 0; i < int'(amt); i++) begin
      case (kind)
        2'b00:   {c, val} = {val, 1'b0};
        2'b01:   {val, c} = {1'b0, val};
        default: {val, c} = {val[31], val};
      endcase
    end
  end
  return {c, val};
endfunction

// Reference ALU with per-opcode overflow rules
function automatic void modelAlu(input armExecPkg::aluOp op, input logic [31:0] rn,
                                 input logic [31:0] op2, input logic shC,
                                 input armExecPkg::nzcvFlags fIn, output logic [31:0] res,
                                 output armExecPkg::nzcvFlags fOut);
  logic [32:0] wide;
  logic        arith;
  logic        ovf;
  arith = op inside {armExecPkg::opSub, armExecPkg::opRsb, armExecPkg::opAdd,
                     armExecPkg::opAdc, armExecPkg::opSbc, armExecPkg::opRsc,
                     armExecPkg::opCmp, armExecPkg::opCmn};
  wide  = '0;
  res   = '0;
  case (op)
    armExecPkg::opAnd, armExecPkg::opTst: res = rn & op2;
    armExecPkg::opEor, armExecPkg::opTeq: res = rn ^ op2;
    armExecPkg::opOrr: res = rn | op2;
    armExecPkg::opMov: res = op2;
    armExecPkg::opBic: res = rn & ~op2;
    armExecPkg::opMvn: res = ~op2;
    armExecPkg::opAdd, armExecPkg::opCmn: wide = {1'b0, rn} + {1'b0, op2};
    armExecPkg::opAdc: wide = {1'b0, rn} + {1'b0, op2} + {32'd0, fIn.c};
    armExecPkg::opSub, armExecPkg::opCmp: wide = {1'b0, rn} + {1'b0, ~op2} + 33'd1;
    armExecPkg::opSbc: wide = {1'b0, rn} + {1'b0, ~op2} + {32'd0, fIn.c};
    armExecPkg::opRsb: wide = {1'b0, op2} + {1'b0, ~rn} + 33'd1;
    default: wide = {1'b0, op2} + {1'b0, ~rn} + {32'd0, fIn.c};  // RSC
  endcase
  if (arith) begin
    res = wide[31:0];
  end
  case (op)
    armExecPkg::opAdd, armExecPkg::opCmn, armExecPkg::opAdc:
      ovf = (rn[31] == op2[31]) && (res[31] != rn[31]);
    armExecPkg::opRsb, armExecPkg::opRsc:
      ovf = (op2[31] != rn[31]) && (res[31] != op2[31]);
    default: ovf = (rn[31] != op2[31]) && (res[31] != rn[31]);
  endcase
  fOut.n = res[31];
  fOut.z = (res == 32'd0);
  fOut.c = arith ? wide[32] : shC;
  fOut.v = arith ? ovf : fIn.v;
endfunction

function automatic logic modelCond(input logic [3:0] cond, input armExecPkg::nzcvFlags f);
  logic pass;
  case (cond)
    4'd0: pass = f.z;
    4'd1: pass = !f.z;
    4'd2: pass = f.c;
    4'd3: pass = !f.c;
    4'd4: pass = f.n;
    4'd5: pass = !f.n;
    4'd6: pass = f.v;
    4'd7: pass = !f.v;
    4'd8: pass = f.c && !f.z;
    4'd9: pass = !f.c || f.z;
    4'd10: pass = (f.n == f.v);
    4'd11: pass = (f.n != f.v);
    4'd12: pass = !f.z && (f.n == f.v);
    4'd13: pass = f.z || (f.n != f.v);
    4'd14: pass = 1'b1;
    default: pass = 1'b0;
  endcase
  return pass;
endfunction

`endif

/* testbench/executeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStageTb;

  localparam int numInstr   = 2000;
  localparam int cycleLimit = 20000;
  localparam int drainLimit = 4;

  logic                                clk = 1'b0;
  logic                                rstN;
  logic                                instrValid;
  logic [armExecPkg::dataWidth-1:0]    instr;
  logic [armExecPkg::dataWidth-1:0]    rnValue;
  logic [armExecPkg::dataWidth-1:0]    rmValue;
  logic [armExecPkg::dataWidth-1:0]    rsValue;
  logic                                resultValid;
  logic [armExecPkg::dataWidth-1:0]    result;
  logic [armExecPkg::regAddrWidth-1:0] rdAddr;
  logic                                regWrite;
  armExecPkg::nzcvFlags                flags;

  logic [31:0]          lfsrState;
  armExecPkg::nzcvFlags modelFlags;  // Model's own NZCV copy
  logic                 expValid;
  logic                 expRegWrite;
  logic [31:0]          expResult;
  logic [3:0]           expRd;
  string                testName;
  int                   issued;
  int                   cycles;
  int                   drainCycles;

  `include "execModel.svh"

  executeStage u_dut (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .instr       (instr),
    .rnValue     (rnValue),
    .rmValue     (rmValue),
    .rsValue     (rsValue),
    .resultValid (resultValid),
    .result      (result),
    .rdAddr      (rdAddr),
    .regWrite    (regWrite),
    .flags       (flags)
  );

  always #2 clk = ~clk;  // 4 ns period

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic randBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);  // One step per bit
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("FAILED %s %s: expected %h, actual %h", testName, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "Output mismatch");
      end
  endtask

  task automatic failTimeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped by timeout");
  endtask

  task automatic checkOutputs();
    checkValue("resultValid", {31'd0, expValid}, {31'd0, resultValid});
    checkValue("regWrite", {31'd0, expRegWrite}, {31'd0, regWrite});
    checkValue("flags", {28'd0, modelFlags}, {28'd0, flags});
    if (expValid) begin
      checkValue("result", expResult, result);
      checkValue("rdAddr", {28'd0, expRd}, {28'd0, rdAddr});
    end
  endtask

  // Called at the rising edge while the DUT samples the current inputs
  task automatic modelStep();
    logic [32:0]          sh;
    logic [31:0]          res;
    armExecPkg::nzcvFlags nf;
    armExecPkg::aluOp     op;
    logic                 pass;
    expValid    = instrValid;
    expRegWrite = 1'b0;
    if (instrValid) begin
      op = armExecPkg::aluOp'(instr[24:21]);
      sh = modelShift(instr, rmValue, rsValue, modelFlags.c);
      modelAlu(op, rnValue, sh[31:0], sh[32], modelFlags, res, nf);
      pass        = modelCond(instr[31:28], modelFlags);
      expResult   = res;
      expRd       = instr[15:12];
      expRegWrite = pass && !(op inside {armExecPkg::opTst, armExecPkg::opTeq,
                                         armExecPkg::opCmp, armExecPkg::opCmn});
      if (pass && instr[20]) begin
        modelFlags = nf;  // S bit on a passing instruction
      end
    end
  endtask

  task automatic driveNext();
    logic [31:0] word;
    logic [31:0] rn;
    logic [31:0] rm;
    logic [31:0] rs;
    logic [31:0] pick;
    randBits(32, word);
    word[27:26] = 2'b00;  // Data-processing class
    randBits(2, pick);
    if (pick[1:0] == 2'd0) begin
      word[25] = 1'b1;  // Rotated immediate
    end else if (pick[1:0] == 2'd1) begin
      word[25] = 1'b0;
      word[4]  = 1'b0;  // Shift by imm5
      randBits(2, pick);
      if (pick[1:0] == 2'd0) begin
        word[11:7] = 5'd0;  // More RRX and zero shifts
      end
    end else begin
      word[25] = 1'b0;
      word[7]  = 1'b0;
      word[4]  = 1'b1;  // Shift by Rs
    end
    randBits(1, pick);
    if (pick[0]) begin
      word[31:28] = 4'd14;  // Bias toward AL
    end
    randBits(32, rn);
    randBits(32, rm);
    randBits(32, rs);
    randBits(3, pick);
    case (pick[2:0])  // Saturation corners
      3'd0: rs[7:0] = 8'd0;
      3'd1: rs[7:0] = 8'd31;
      3'd2: rs[7:0] = 8'd32;
      3'd3: rs[7:0] = 8'd33;
      3'd4: rs[7:0] = 8'd255;
      default: ;
    endcase
    randBits(2, pick);
    instrValid <= (pick[1:0] != 2'd0);
    instr      <= word;
    rnValue    <= rn;
    rmValue    <= rm;
    rsValue    <= rs;
    if (pick[1:0] != 2'd0) begin
      issued++;
    end
  endtask

  initial begin
    rstN        <= 1'b0;
    instrValid  <= 1'b0;
    instr       <= '0;
    rnValue     <= '0;
    rmValue     <= '0;
    rsValue     <= '0;
    lfsrState   = 32'h5c9eb66d;
    modelFlags  = '0;
    expValid    = 1'b0;
    expRegWrite = 1'b0;
    expResult   = '0;
    expRd       = '0;
    issued      = 0;
    cycles      = 0;
    drainCycles = 0;
    testName    = "reset";
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkOutputs();

    testName = "random";
    while (issued < numInstr) begin
      @(posedge clk);
      modelStep();
      driveNext();
      @(negedge clk);  // Outputs settled
      checkOutputs();
      cycles++;
      if (cycles > cycleLimit) begin
        failTimeout("the instruction stream to finish");
      end
    end

    // Last valid instruction is sampled at this edge
    @(posedge clk);
    modelStep();
    instrValid <= 1'b0;
    do begin
      @(negedge clk);
      checkOutputs();
      drainCycles++;
      if (!resultValid && drainCycles >= drainLimit) begin
        failTimeout("the last result");
      end
    end while (!resultValid);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* source/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                instrValid,
  input  logic [armExecPkg::dataWidth-1:0]    instr,
  input  logic [armExecPkg::dataWidth-1:0]    rnValue,
  input  logic [armExecPkg::dataWidth-1:0]    rmValue,
  input  logic [armExecPkg::dataWidth-1:0]    rsValue,
  output logic                                resultValid,
  output logic [armExecPkg::dataWidth-1:0]    result,
  output logic [armExecPkg::regAddrWidth-1:0] rdAddr,
  output logic                                regWrite,
  output armExecPkg::nzcvFlags                flags
);

  armExecPkg::aluCtrl               ctrl;
  armExecPkg::shiftCtrl             shCtrl;
  armExecPkg::nzcvFlags             newFlags;
  logic [armExecPkg::dataWidth-1:0] shiftIn;
  logic [armExecPkg::dataWidth-1:0] operand2;
  logic [armExecPkg::dataWidth-1:0] aluResult;
  logic                             shiftCarry;
  logic                             writesRd;
  logic                             condPass;

  operand2Decode u_decode (
    .instr   (instr),
    .rmValue (rmValue),
    .rsValue (rsValue),
    .ctrl    (ctrl),
    .shCtrl  (shCtrl),
    .shiftIn (shiftIn)
  );

  barrelShifter u_shifter (
    .shCtrl     (shCtrl),
    .shiftIn    (shiftIn),
    .carryIn    (flags.c),  // RRX and zero shifts use the current C
    .shifted    (operand2),
    .shiftCarry (shiftCarry)
  );

  armAlu u_alu (
    .op         (ctrl.op),
    .rn         (rnValue),
    .operand2   (operand2),
    .shiftCarry (shiftCarry),
    .flagsIn    (flags),
    .aluResult  (aluResult),
    .newFlags   (newFlags),
    .writesRd   (writesRd)
  );

  condFlags u_flags (
    .clk        (clk),
    .rstN       (rstN),
    .cond       (ctrl.cond),
    .instrValid (instrValid),
    .setFlags   (ctrl.setFlags),
    .newFlags   (newFlags),
    .flags      (flags),
    .condPass   (condPass)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      regWrite    <= 1'b0;
    end else begin
      resultValid <= instrValid;  // One-cycle strobe
      regWrite    <= instrValid && condPass && writesRd;
    end
  end

  // Payload captured only on valid instructions
  always_ff @(posedge clk) begin
    if (instrValid) begin
      result <= aluResult;
      rdAddr <= ctrl.rd;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) regWrite |-> resultValid)
    else $error("regWrite without resultValid");

endmodule

`default_nettype wire

/* source/condFlags.sv */
`timescale 1ns/1ps
`default_nettype none

module condFlags (
  input  logic                 clk,
  input  logic                 rstN,
  input  armExecPkg::condCode  cond,
  input  logic                 instrValid,
  input  logic                 setFlags,
  input  armExecPkg::nzcvFlags newFlags,
  output armExecPkg::nzcvFlags flags,
  output logic                 condPass
);

  logic flagsLoad;

  assign flagsLoad = instrValid && condPass && setFlags;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (flagsLoad) begin
      flags <= newFlags;
    end
  end

  // ARM condition table on the registered flags
  always_comb begin
    case (cond)
      armExecPkg::condEq: condPass = flags.z;
      armExecPkg::condNe: condPass = !flags.z;
      armExecPkg::condCs: condPass = flags.c;
      armExecPkg::condCc: condPass = !flags.c;
      armExecPkg::condMi: condPass = flags.n;
      armExecPkg::condPl: condPass = !flags.n;
      armExecPkg::condVs: condPass = flags.v;
      armExecPkg::condVc: condPass = !flags.v;
      armExecPkg::condHi: condPass = flags.c && !flags.z;
      armExecPkg::condLs: condPass = !flags.c || flags.z;
      armExecPkg::condGe: condPass = (flags.n == flags.v);
      armExecPkg::condLt: condPass = (flags.n != flags.v);
      armExecPkg::condGt: condPass = !flags.z && (flags.n == flags.v);
      armExecPkg::condLe: condPass = flags.z || (flags.n != flags.v);
      armExecPkg::condAl: condPass = 1'b1;
      default:            condPass = 1'b0;  // Never
    endcase
  end

  // No flag change without a passing S-bit instruction the cycle before
  assert property (@(posedge clk) disable iff (!rstN)
    !flagsLoad |=> $stable(flags))
    else $error("Flags changed without a flag-setting instruction");

endmodule

`default_nettype wire

/* source/armAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module armAlu (
  input  armExecPkg::aluOp                 op,
  input  logic [armExecPkg::dataWidth-1:0] rn,
  input  logic [armExecPkg::dataWidth-1:0] operand2,
  input  logic                             shiftCarry,
  input  armExecPkg::nzcvFlags             flagsIn,
  output logic [armExecPkg::dataWidth-1:0] aluResult,
  output armExecPkg::nzcvFlags             newFlags,
  output logic                             writesRd
);

  logic [armExecPkg::dataWidth-1:0] addA;
  logic [armExecPkg::dataWidth-1:0] addB;
  logic                             addCin;
  logic                             isArith;
  logic [armExecPkg::dataWidth:0]   sum;
  logic                             overflow;
  logic [armExecPkg::dataWidth-1:0] logicResult;

  // Operand inversion and carry-in select for the shared adder
  always_comb begin
    addA    = rn;
    addB    = operand2;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (op)
      armExecPkg::opSub, armExecPkg::opCmp: begin
        addB   = ~operand2;  // rn - op2
        addCin = 1'b1;
      end
      armExecPkg::opRsb: begin
        addA   = ~rn;  // op2 - rn
        addCin = 1'b1;
      end
      armExecPkg::opAdd, armExecPkg::opCmn: addCin = 1'b0;
      armExecPkg::opAdc: addCin = flagsIn.c;
      armExecPkg::opSbc: begin
        addB   = ~operand2;
        addCin = flagsIn.c;  // Borrow is NOT C
      end
      armExecPkg::opRsc: begin
        addA   = ~rn;
        addCin = flagsIn.c;
      end
      default: isArith = 1'b0;
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} +
               {{armExecPkg::dataWidth{1'b0}}, addCin};

  // Same-sign inputs with a different-sign sum
  assign overflow = (addA[armExecPkg::dataWidth-1] == addB[armExecPkg::dataWidth-1]) &&
                    (sum[armExecPkg::dataWidth-1] != addA[armExecPkg::dataWidth-1]);

  always_comb begin
    case (op)
      armExecPkg::opAnd, armExecPkg::opTst: logicResult = rn & operand2;
      armExecPkg::opEor, armExecPkg::opTeq: logicResult = rn ^ operand2;
      armExecPkg::opOrr:                    logicResult = rn | operand2;
      armExecPkg::opMov:                    logicResult = operand2;
      armExecPkg::opBic:                    logicResult = rn & ~operand2;
      armExecPkg::opMvn:                    logicResult = ~operand2;
      default:                              logicResult = '0;  // Arithmetic ops
    endcase
  end

  assign aluResult = isArith ? sum[armExecPkg::dataWidth-1:0] : logicResult;

  always_comb begin
    newFlags.n = aluResult[armExecPkg::dataWidth-1];
    newFlags.z = (aluResult == '0);
    newFlags.c = isArith ? sum[armExecPkg::dataWidth] : shiftCarry;  // No-borrow on subtract
    newFlags.v = isArith ? overflow : flagsIn.v;  // Logic ops keep V
  end

  // Compare and test opcodes only set flags
  assign writesRd = !(op inside {armExecPkg::opTst, armExecPkg::opTeq,
                                 armExecPkg::opCmp, armExecPkg::opCmn});

endmodule

`default_nettype wire

/* source/barrelShifter.sv */
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
  input  armExecPkg::shiftCtrl             shCtrl,
  input  logic [armExecPkg::dataWidth-1:0] shiftIn,
  input  logic                             carryIn,
  output logic [armExecPkg::dataWidth-1:0] shifted,
  output logic                             shiftCarry
);

  logic [2*armExecPkg::dataWidth-1:0] rotWide;
  logic [armExecPkg::dataWidth:0]     lslWide;  // {carry, value}
  logic [armExecPkg::dataWidth:0]     lsrWide;  // {value, carry}
  logic [armExecPkg::dataWidth:0]     asrWide;  // {value, carry}
  logic                               zeroAmt;

  assign zeroAmt = (shCtrl.amount == 8'd0);

  // Rotate by doubling the operand with the amount taken modulo 32
  assign rotWide = {shiftIn, shiftIn} >> shCtrl.amount[4:0];

  // One extra bit catches the last bit shifted out
  // Amounts of 32 and up saturate on their own in the 33-bit shifts
  assign lslWide = {1'b0, shiftIn} << shCtrl.amount;
  assign lsrWide = {shiftIn, 1'b0} >> shCtrl.amount;
  assign asrWide = $signed({shiftIn, 1'b0}) >>> shCtrl.amount;  // Sign fill past 32

  always_comb begin
    shifted    = shiftIn;  // Amount 0 passes through
    shiftCarry = carryIn;  // and keeps old C
    case (shCtrl.kind)
      armExecPkg::shLsl: begin
        if (!zeroAmt) begin
          {shiftCarry, shifted} = lslWide;
        end
      end
      armExecPkg::shLsr: begin
        if (!zeroAmt) begin
          {shifted, shiftCarry} = lsrWide;
        end
      end
      armExecPkg::shAsr: begin
        if (!zeroAmt) begin
          {shifted, shiftCarry} = asrWide;
        end
      end
      default: begin  // ROR
        if (zeroAmt && shCtrl.mode == armExecPkg::byImm) begin
          shifted    = {carryIn, shiftIn[armExecPkg::dataWidth-1:1]};  // RRX
          shiftCarry = shiftIn[0];
        end else if (!zeroAmt) begin
          shifted    = rotWide[armExecPkg::dataWidth-1:0];
          shiftCarry = rotWide[armExecPkg::dataWidth-1];  // MSB of rotated value
        end
      end
    endcase
  end

  // Immediate amounts come from 5-bit fields or 2*rot4 in decode
  always_comb begin
    if (shCtrl.mode != armExecPkg::byReg) begin
      assert (shCtrl.amount < 8'd32)
        else $error("Immediate shift amount %0d out of range", shCtrl.amount);
    end
  end

endmodule

`default_nettype wire

/* source/operand2Decode.sv */
`timescale 1ns/1ps
`default_nettype none

module operand2Decode (
  input  logic [armExecPkg::dataWidth-1:0] instr,
  input  logic [armExecPkg::dataWidth-1:0] rmValue,
  input  logic [armExecPkg::dataWidth-1:0] rsValue,
  output armExecPkg::aluCtrl               ctrl,
  output armExecPkg::shiftCtrl             shCtrl,
  output logic [armExecPkg::dataWidth-1:0] shiftIn
);

  // ALU control straight from fixed fields
  always_comb begin
    ctrl.cond     = armExecPkg::condCode'(instr[31:28]);
    ctrl.op       = armExecPkg::aluOp'(instr[24:21]);
    ctrl.setFlags = instr[20];
    ctrl.rd       = instr[15:12];
  end

  always_comb begin
    if (instr[25]) begin  // Rotated immediate
      shCtrl.mode   = armExecPkg::rotImm;
      shCtrl.kind   = armExecPkg::shRor;
      shCtrl.amount = {3'b000, instr[11:8], 1'b0};  // Twice rot4
      shiftIn       = {{(armExecPkg::dataWidth-8){1'b0}}, instr[7:0]};
    end else begin
      shCtrl.kind = armExecPkg::shiftKind'(instr[6:5]);
      shiftIn     = rmValue;
      if (instr[4]) begin  // Register-specified amount
        shCtrl.mode   = armExecPkg::byReg;
        shCtrl.amount = rsValue[7:0];
      end else begin
        shCtrl.mode   = armExecPkg::byImm;
        shCtrl.amount = {3'b000, instr[11:7]};
      end
    end
  end

endmodule

`default_nettype wire

/* source/armExecPkg.sv */
`default_nettype none

package armExecPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;

  // Data-processing opcodes in instr[24:21]
  typedef enum logic [3:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opRsb = 4'd3,
    opAdd = 4'd4,
    opAdc = 4'd5,
    opSbc = 4'd6,
    opRsc = 4'd7,
    opTst = 4'd8,
    opTeq = 4'd9,
    opCmp = 4'd10,
    opCmn = 4'd11,
    opOrr = 4'd12,
    opMov = 4'd13,
    opBic = 4'd14,
    opMvn = 4'd15
  } aluOp;

  // Condition field in instr[31:28]
  typedef enum logic [3:0] {
    condEq = 4'd0,
    condNe = 4'd1,
    condCs = 4'd2,
    condCc = 4'd3,
    condMi = 4'd4,
    condPl = 4'd5,
    condVs = 4'd6,
    condVc = 4'd7,
    condHi = 4'd8,
    condLs = 4'd9,
    condGe = 4'd10,
    condLt = 4'd11,
    condGt = 4'd12,
    condLe = 4'd13,
    condAl = 4'd14,
    condNv = 4'd15   // Never executes
  } condCode;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftKind;

  // Source of the shift amount
  typedef enum logic [1:0] {
    rotImm = 2'd0,   // imm8 rotated by 2*rot4
    byImm  = 2'd1,   // 5-bit immediate amount
    byReg  = 2'd2    // Low byte of Rs
  } shiftMode;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcvFlags;

  typedef struct packed {
    shiftMode   mode;
    shiftKind   kind;
    logic [7:0] amount;
  } shiftCtrl;

  typedef struct packed {
    condCode                 cond;
    aluOp                    op;
    logic                    setFlags;  // S bit
    logic [regAddrWidth-1:0] rd;
  } aluCtrl;

endpackage

`default_nettype wire
